/* common/divider_pkg.sv */
package divider_pkg;

    // operand and result width of every divider
    localparam int word_width = 16;

    // number of divider lanes behind the dispatcher
    localparam int lane_count = 4;

    // round-robin pointers select one of lane_count lanes
    localparam int lane_index_width = 2;

    // lane payload is the result with the divide-by-zero flag on top
    localparam int result_width = word_width + 1;

    typedef enum logic {
        op_quotient,
        op_remainder
    } div_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } div_state_e;

endpackage

/* logic/pipeline_skid_buffer.sv */
`timescale 1ns/1ps

module pipeline_skid_buffer (
    input  logic                                clock,
    input  logic                                rst,
    input  logic                                input_valid,
    output logic                                input_ready,
    input  logic [divider_pkg::result_width-1:0] input_data,
    output logic                                output_valid,
    input  logic                                output_ready,
    output logic [divider_pkg::result_width-1:0] output_data
);

    logic                                main_valid;
    logic                                skid_valid;
    logic [divider_pkg::result_width-1:0] main_data;
    logic [divider_pkg::result_width-1:0] skid_data;

    // input_ready comes straight from the skid flop so downstream ready
    // never reaches the upstream side in the same cycle
    assign input_ready  = !skid_valid;
    assign output_valid = main_valid;
    assign output_data  = main_data;

    always_ff @(posedge clock) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (skid_valid) begin
            // the skid entry moves up once the main entry is read
            if (output_ready) begin
                skid_valid <= 1'b0;
            end
        end else if (!main_valid || output_ready) begin
            main_valid <= input_valid;
        end else if (input_valid) begin
            // main entry is stalled, so the arriving word parks in the skid
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (skid_valid) begin
            if (output_ready) begin
                main_data <= skid_data;
            end
        end else if (!main_valid || output_ready) begin
            if (input_valid) begin
                main_data <= input_data;
            end
        end else if (input_valid) begin
            skid_data <= input_data;
        end
    end

    // a stalled word must not change under the consumer
    a_output_stable: assert property (
        @(posedge clock) disable iff (rst)
        output_valid && !output_ready |=> output_valid && $stable(output_data)
    );

endmodule

/* lane/iterative_divider.sv */
`timescale 1ns/1ps

module iterative_divider (
    input  logic                               clock,
    input  logic                               rst,
    input  logic                               start,
    input  divider_pkg::div_op_e               op,
    input  logic [divider_pkg::word_width-1:0] dividend,
    input  logic [divider_pkg::word_width-1:0] divisor,
    output logic                               done,
    output logic [divider_pkg::word_width-1:0] result,
    output logic                               div_by_zero
);

    divider_pkg::div_state_e state;
    divider_pkg::div_op_e    op_q;

    logic [$clog2(divider_pkg::word_width)-1:0] step;
    logic [divider_pkg::word_width-1:0]         quo;
    logic [divider_pkg::word_width-1:0]         rem;
    logic [divider_pkg::word_width-1:0]         divisor_q;
    logic [divider_pkg::word_width:0]           shifted;
    logic [divider_pkg::word_width:0]           diff;
    logic                                       fits;
    logic [divider_pkg::word_width-1:0]         next_quo;
    logic [divider_pkg::word_width-1:0]         next_rem;

    // each cycle runs one restoring step
    // quo starts as the dividend and fills with quotient bits from the right
    // as the dividend shifts out
    always_comb begin
        shifted  = {rem, quo[divider_pkg::word_width-1]};
        diff     = shifted - {1'b0, divisor_q};
        fits     = shifted >= {1'b0, divisor_q};
        next_quo = {quo[divider_pkg::word_width-2:0], fits};
        next_rem = fits ? diff[divider_pkg::word_width-1:0] : shifted[divider_pkg::word_width-1:0];
    end

    assign done = state == divider_pkg::st_done;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= divider_pkg::st_idle;
            step  <= '0;
        end else begin
            case (state)
                divider_pkg::st_idle: begin
                    if (start) begin
                        state <= divider_pkg::st_run;
                        step  <= '0;
                    end
                end
                divider_pkg::st_run: begin
                    step <= step + 1'b1;
                    // the last of word_width steps lands the result
                    if (step == '1) begin
                        state <= divider_pkg::st_done;
                    end
                end
                default: state <= divider_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == divider_pkg::st_idle && start) begin
            quo       <= dividend;
            rem       <= '0;
            divisor_q <= divisor;
            op_q      <= op;
        end else if (state == divider_pkg::st_run) begin
            quo <= next_quo;
            rem <= next_rem;
            if (step == '1) begin
                div_by_zero <= divisor_q == '0;
                // a zero divisor fits at every step, so the quotient fills with
                // ones and the remainder collects the whole dividend
                result <= (op_q == divider_pkg::op_quotient) ? next_quo : next_rem;
            end
        end
    end

    // the lane holds off new work until the previous result is handed over
    a_start_idle: assert property (
        @(posedge clock) disable iff (rst) start |-> state == divider_pkg::st_idle
    );

endmodule

/* lane/pulse_to_pipeline.sv */
`timescale 1ns/1ps

module pulse_to_pipeline (
    input  logic                                clock,
    input  logic                                rst,
    input  logic [divider_pkg::result_width-1:0] module_data_out,
    input  logic                                module_data_out_valid,
    output logic                                module_ready,
    output logic                                valid_out,
    input  logic                                ready_out,
    output logic [divider_pkg::result_width-1:0] data_out
);

    logic valid_latched;
    logic valid_internal;
    logic ready_internal;
    logic handover;

    // the live pulse is passed on as well as latched, which saves a cycle
    // when the skid buffer can take the result right away
    assign valid_internal = valid_latched || module_data_out_valid;
    assign handover       = valid_internal && ready_internal;
    assign module_ready   = handover;

    // set by the done pulse and cleared when the skid buffer takes the data
    always_ff @(posedge clock) begin
        if (rst) begin
            valid_latched <= 1'b0;
        end else if (handover) begin
            valid_latched <= 1'b0;
        end else if (module_data_out_valid) begin
            valid_latched <= 1'b1;
        end
    end

    // the divider holds its output registers, so the data needs no copy here
    pipeline_skid_buffer u_output_buffer (
        .clock        (clock),
        .rst          (rst),
        .input_valid  (valid_internal),
        .input_ready  (ready_internal),
        .input_data   (module_data_out),
        .output_valid (valid_out),
        .output_ready (ready_out),
        .output_data  (data_out)
    );

endmodule

/* lane/divider_lane.sv */
`timescale 1ns/1ps

module divider_lane (
    input  logic                               clock,
    input  logic                               rst,
    input  logic                               lane_in_valid,
    output logic                               lane_in_ready,
    input  divider_pkg::div_op_e               lane_in_op,
    input  logic [divider_pkg::word_width-1:0] lane_in_dividend,
    input  logic [divider_pkg::word_width-1:0] lane_in_divisor,
    output logic                               lane_out_valid,
    input  logic                               lane_out_ready,
    output logic [divider_pkg::word_width-1:0] lane_out_result,
    output logic                               lane_out_div_by_zero
);

    divider_pkg::div_op_e op_q;

    logic                                 accept;
    logic                                 busy;
    logic                                 start;
    logic                                 done;
    logic                                 module_ready;
    logic                                 div_by_zero;
    logic [divider_pkg::word_width-1:0]   dividend_q;
    logic [divider_pkg::word_width-1:0]   divisor_q;
    logic [divider_pkg::word_width-1:0]   result;
    logic [divider_pkg::result_width-1:0] out_payload;

    assign accept        = lane_in_valid && lane_in_ready;
    assign lane_in_ready = !busy;

    // busy covers the whole divide plus any wait for the skid buffer
    always_ff @(posedge clock) begin
        if (rst) begin
            busy  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (module_ready) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            op_q       <= lane_in_op;
            dividend_q <= lane_in_dividend;
            divisor_q  <= lane_in_divisor;
        end
    end

    iterative_divider u_divider (
        .clock       (clock),
        .rst         (rst),
        .start       (start),
        .op          (op_q),
        .dividend    (dividend_q),
        .divisor     (divisor_q),
        .done        (done),
        .result      (result),
        .div_by_zero (div_by_zero)
    );

    // flag rides above the result through the output buffer
    pulse_to_pipeline u_pulse_to_pipeline (
        .clock                 (clock),
        .rst                   (rst),
        .module_data_out       ({div_by_zero, result}),
        .module_data_out_valid (done),
        .module_ready          (module_ready),
        .valid_out             (lane_out_valid),
        .ready_out             (lane_out_ready),
        .data_out              (out_payload)
    );

    assign {lane_out_div_by_zero, lane_out_result} = out_payload;

endmodule

/* logic/lane_dispatcher.sv */
`timescale 1ns/1ps

module lane_dispatcher (
    input  logic                               clock,
    input  logic                               rst,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  divider_pkg::div_op_e               in_op,
    input  logic [divider_pkg::word_width-1:0] in_dividend,
    input  logic [divider_pkg::word_width-1:0] in_divisor,
    output logic [divider_pkg::lane_count-1:0] lane_in_valid,
    input  logic [divider_pkg::lane_count-1:0] lane_in_ready,
    output divider_pkg::div_op_e               lane_in_op [divider_pkg::lane_count],
    output logic [divider_pkg::word_width-1:0] lane_in_dividend [divider_pkg::lane_count],
    output logic [divider_pkg::word_width-1:0] lane_in_divisor [divider_pkg::lane_count]
);

    logic [divider_pkg::lane_index_width-1:0] issue_ptr;

    // only the lane under the pointer sees valid, and its ready is ours
    assign in_ready = lane_in_ready[issue_ptr];

    always_comb begin
        for (int i = 0; i < divider_pkg::lane_count; i++) begin
            lane_in_valid[i]    = in_valid && issue_ptr == i[divider_pkg::lane_index_width-1:0];
            lane_in_op[i]       = in_op;
            lane_in_dividend[i] = in_dividend;
            lane_in_divisor[i]  = in_divisor;
        end
    end

    // the pointer wraps on its own since lane_count is a power of two
    always_ff @(posedge clock) begin
        if (rst) begin
            issue_ptr <= '0;
        end else if (in_valid && in_ready) begin
            issue_ptr <= issue_ptr + 1'b1;
        end
    end

    // a waiting request must stay put until the lane under the pointer takes it
    a_request_held: assert property (
        @(posedge clock) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable({in_op, in_dividend, in_divisor})
    );

endmodule

/* logic/lane_collector.sv */
`timescale 1ns/1ps

module lane_collector (
    input  logic                               clock,
    input  logic                               rst,
    input  logic [divider_pkg::lane_count-1:0] lane_out_valid,
    output logic [divider_pkg::lane_count-1:0] lane_out_ready,
    input  logic [divider_pkg::word_width-1:0] lane_out_result [divider_pkg::lane_count],
    input  logic [divider_pkg::lane_count-1:0] lane_out_div_by_zero,
    output logic                               out_valid,
    input  logic                               out_ready,
    output logic [divider_pkg::word_width-1:0] out_result,
    output logic                               out_div_by_zero
);

    logic [divider_pkg::lane_index_width-1:0] drain_ptr;

    // draining in issue order keeps results in request order, even when
    // a later lane finishes first it waits for its turn
    assign out_valid       = lane_out_valid[drain_ptr];
    assign out_result      = lane_out_result[drain_ptr];
    assign out_div_by_zero = lane_out_div_by_zero[drain_ptr];

    always_comb begin
        for (int i = 0; i < divider_pkg::lane_count; i++) begin
            lane_out_ready[i] = out_ready && drain_ptr == i[divider_pkg::lane_index_width-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            drain_ptr <= '0;
        end else if (out_valid && out_ready) begin
            drain_ptr <= drain_ptr + 1'b1;
        end
    end

endmodule

/* logic/divider_array.sv */
`timescale 1ns/1ps

module divider_array (
    input  logic                               clock,
    input  logic                               rst,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  divider_pkg::div_op_e               in_op,
    input  logic [divider_pkg::word_width-1:0] in_dividend,
    input  logic [divider_pkg::word_width-1:0] in_divisor,
    output logic                               out_valid,
    input  logic                               out_ready,
    output logic [divider_pkg::word_width-1:0] out_result,
    output logic                               out_div_by_zero
);

    logic [divider_pkg::lane_count-1:0] lane_in_valid;
    logic [divider_pkg::lane_count-1:0] lane_in_ready;
    logic [divider_pkg::lane_count-1:0] lane_out_valid;
    logic [divider_pkg::lane_count-1:0] lane_out_ready;
    logic [divider_pkg::lane_count-1:0] lane_out_div_by_zero;

    divider_pkg::div_op_e               lane_in_op [divider_pkg::lane_count];
    logic [divider_pkg::word_width-1:0] lane_in_dividend [divider_pkg::lane_count];
    logic [divider_pkg::word_width-1:0] lane_in_divisor [divider_pkg::lane_count];
    logic [divider_pkg::word_width-1:0] lane_out_result [divider_pkg::lane_count];

    lane_dispatcher u_dispatcher (
        .clock            (clock),
        .rst              (rst),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .in_op            (in_op),
        .in_dividend      (in_dividend),
        .in_divisor       (in_divisor),
        .lane_in_valid    (lane_in_valid),
        .lane_in_ready    (lane_in_ready),
        .lane_in_op       (lane_in_op),
        .lane_in_dividend (lane_in_dividend),
        .lane_in_divisor  (lane_in_divisor)
    );

    for (genvar g = 0; g < divider_pkg::lane_count; g++) begin : g_lane
        divider_lane u_lane (
            .clock                (clock),
            .rst                  (rst),
            .lane_in_valid        (lane_in_valid[g]),
            .lane_in_ready        (lane_in_ready[g]),
            .lane_in_op           (lane_in_op[g]),
            .lane_in_dividend     (lane_in_dividend[g]),
            .lane_in_divisor      (lane_in_divisor[g]),
            .lane_out_valid       (lane_out_valid[g]),
            .lane_out_ready       (lane_out_ready[g]),
            .lane_out_result      (lane_out_result[g]),
            .lane_out_div_by_zero (lane_out_div_by_zero[g])
        );
    end

    lane_collector u_collector (
        .clock                (clock),
        .rst                  (rst),
        .lane_out_valid       (lane_out_valid),
        .lane_out_ready       (lane_out_ready),
        .lane_out_result      (lane_out_result),
        .lane_out_div_by_zero (lane_out_div_by_zero),
        .out_valid            (out_valid),
        .out_ready            (out_ready),
        .out_result           (out_result),
        .out_div_by_zero      (out_div_by_zero)
    );

endmodule

/* test/divider_checker.sv */
`timescale 1ns/1ps

module divider_checker (
    input  logic                               clock,
    input  logic                               rst,
    input  logic                               in_valid,
    input  logic                               in_ready,
    input  divider_pkg::div_op_e               in_op,
    input  logic [divider_pkg::word_width-1:0] in_dividend,
    input  logic [divider_pkg::word_width-1:0] in_divisor,
    input  logic                               out_valid,
    input  logic                               out_ready,
    input  logic [divider_pkg::word_width-1:0] out_result,
    input  logic                               out_div_by_zero,
    output int                                 error_count,
    output int                                 result_count,
    output int                                 pending
);

    // each entry is {op, dividend, divisor}, oldest request at the front
    logic [2*divider_pkg::word_width:0] request_q [$];

    // unsigned divide with the zero-divisor rule, flag on top of the value
    function automatic logic [divider_pkg::result_width-1:0] reference_result(
        input divider_pkg::div_op_e               op,
        input logic [divider_pkg::word_width-1:0] dividend,
        input logic [divider_pkg::word_width-1:0] divisor
    );
        logic [divider_pkg::word_width-1:0] value;
        logic                               flag;
        if (divisor == '0) begin
            flag  = 1'b1;
            value = (op == divider_pkg::op_quotient) ? '1 : dividend;
        end else begin
            flag  = 1'b0;
            value = (op == divider_pkg::op_quotient) ? dividend / divisor : dividend % divisor;
        end
        return {flag, value};
    endfunction

    // both ports are sampled on the edge where the transfer happens
    always @(posedge clock) begin : compare
        logic [2*divider_pkg::word_width:0]   request;
        logic [divider_pkg::result_width-1:0] expected;
        divider_pkg::div_op_e                 op;
        logic [divider_pkg::word_width-1:0]   dividend;
        logic [divider_pkg::word_width-1:0]   divisor;
        int                                   mismatches;
        mismatches = 0;
        if (!rst) begin
            if (out_valid && out_ready) begin
                result_count <= result_count + 1;
                if (request_q.size() == 0) begin
                    $display("a result 0x%h came out with no request outstanding", out_result);
                    mismatches++;
                end else begin
                    request  = request_q.pop_front();
                    op       = divider_pkg::div_op_e'(request[2*divider_pkg::word_width]);
                    dividend = request[2*divider_pkg::word_width-1:divider_pkg::word_width];
                    divisor  = request[divider_pkg::word_width-1:0];
                    expected = reference_result(op, dividend, divisor);
                    if (out_result !== expected[divider_pkg::word_width-1:0]) begin
                        $display("Fail out_result: expected 0x%h, got 0x%h (%s 0x%h / 0x%h)",
                                 expected[divider_pkg::word_width-1:0], out_result,
                                 op.name(), dividend, divisor);
                        mismatches++;
                    end
                    if (out_div_by_zero !== expected[divider_pkg::word_width]) begin
                        $display("Fail out_div_by_zero: expected 0x%h, got 0x%h (%s 0x%h / 0x%h)",
                                 expected[divider_pkg::word_width], out_div_by_zero,
                                 op.name(), dividend, divisor);
                        mismatches++;
                    end
                end
            end
            if (in_valid && in_ready) begin
                request_q.push_back({in_op, in_dividend, in_divisor});
            end
            error_count <= error_count + mismatches;
            pending     <= request_q.size();
        end
    end

endmodule

/* test/tb_divider_array.sv */
`timescale 1ns/1ps

module tb_divider_array;

    localparam int directed_count = 12;
    localparam int random_count   = 200;
    localparam int request_total  = directed_count + 2 * random_count;
    // a request may have to wait for every lane to finish before it is taken
    localparam int timeout_cycles =
        request_total * 4 * (divider_pkg::word_width + 3) + 2000;

    logic                               clock       = 1'b0;
    logic                               rst         = 1'b1;
    logic                               in_valid    = 1'b0;
    logic                               in_ready;
    divider_pkg::div_op_e               in_op       = divider_pkg::op_quotient;
    logic [divider_pkg::word_width-1:0] in_dividend = '0;
    logic [divider_pkg::word_width-1:0] in_divisor  = '0;
    logic                               out_valid;
    logic                               out_ready   = 1'b0;
    logic [divider_pkg::word_width-1:0] out_result;
    logic                               out_div_by_zero;

    // when set, the consumer drops out_ready about half of the time
    logic throttle = 1'b0;

    int cycle_count  = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int reset_errors = 0;
    int checker_errors;
    int results_seen;
    int pending;

    always #5 clock = ~clock;

    divider_array u_divider_array (
        .clock           (clock),
        .rst             (rst),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_op           (in_op),
        .in_dividend     (in_dividend),
        .in_divisor      (in_divisor),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_result      (out_result),
        .out_div_by_zero (out_div_by_zero)
    );

    divider_checker u_checker (
        .clock           (clock),
        .rst             (rst),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_op           (in_op),
        .in_dividend     (in_dividend),
        .in_divisor      (in_divisor),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_result      (out_result),
        .out_div_by_zero (out_div_by_zero),
        .error_count     (checker_errors),
        .result_count    (results_seen),
        .pending         (pending)
    );

    always @(posedge clock) begin
        if (throttle) begin
            out_ready <= $urandom_range(0, 1) != 0;
        end else begin
            out_ready <= 1'b1;
        end
    end

    // watchdog, a lost result would otherwise stall the drain forever
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("the run timed out after %0d cycles with %0d results outstanding",
                     cycle_count, pending);
            $display("Simulation failed");
            $finish;
        end
    end

    // called right after a rising edge, returns on the edge of the transfer
    task automatic send_request(
        input divider_pkg::div_op_e               op,
        input logic [divider_pkg::word_width-1:0] dividend,
        input logic [divider_pkg::word_width-1:0] divisor
    );
        in_valid    <= 1'b1;
        in_op       <= op;
        in_dividend <= dividend;
        in_divisor  <= divisor;
        @(negedge clock);
        while (!in_ready) begin
            @(negedge clock);
        end
        @(posedge clock);
        in_valid <= 1'b0;
    endtask

    // returns on a rising edge once every accepted request has come out
    task automatic wait_drained();
        @(negedge clock);
        while (pending != 0) begin
            @(negedge clock);
        end
        @(posedge clock);
    endtask

    task automatic send_and_drain(
        input divider_pkg::div_op_e               op,
        input logic [divider_pkg::word_width-1:0] dividend,
        input logic [divider_pkg::word_width-1:0] divisor
    );
        send_request(op, dividend, divisor);
        wait_drained();
    endtask

    task automatic send_random_burst(input int count);
        logic [31:0]                        r;
        logic [divider_pkg::word_width-1:0] divisor;
        for (int i = 0; i < count; i++) begin
            r       = $urandom;
            divisor = r[divider_pkg::word_width-1:0];
            // narrow divisors now and then, so quotients are not mostly zero
            case ($urandom_range(0, 7))
                0: divisor = '0;
                1, 2, 3: divisor = divisor >> $urandom_range(0, divider_pkg::word_width - 1);
                default: ;
            endcase
            r = $urandom;
            send_request(divider_pkg::div_op_e'(r[31]), r[divider_pkg::word_width-1:0], divisor);
        end
        wait_drained();
    endtask

    task automatic check_reset_state();
        if (out_valid !== 1'b0) begin
            $display("Fail out_valid: expected 0x0, got 0x%h", out_valid);
            reset_errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("Fail in_ready: expected 0x1, got 0x%h", in_ready);
            reset_errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before, input int results_before);
        int errors;
        errors = checker_errors + reset_errors - errors_before;
        if (errors == 0) begin
            tests_passed++;
            $display("test %s passed, %0d results checked", name, results_seen - results_before);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors);
        end
    endtask

    initial begin
        int mark_errors;
        int mark_results;
        void'($urandom(32'hb5159c87));
        repeat (3) @(posedge clock);
        rst <= 1'b0;

        @(negedge clock);
        check_reset_state();
        @(posedge clock);
        report_test("reset state", 0, 0);

        mark_errors  = checker_errors + reset_errors;
        mark_results = results_seen;
        send_and_drain(divider_pkg::op_quotient, 16'd100, 16'd7);
        send_and_drain(divider_pkg::op_remainder, 16'd100, 16'd7);
        send_and_drain(divider_pkg::op_quotient, 16'd65535, 16'd1);
        send_and_drain(divider_pkg::op_remainder, 16'd65535, 16'd1);
        send_and_drain(divider_pkg::op_quotient, 16'd7, 16'd100);
        send_and_drain(divider_pkg::op_remainder, 16'd7, 16'd100);
        send_and_drain(divider_pkg::op_quotient, 16'd65535, 16'd65535);
        send_and_drain(divider_pkg::op_remainder, 16'd1234, 16'd256);
        report_test("directed divides", mark_errors, mark_results);

        mark_errors  = checker_errors + reset_errors;
        mark_results = results_seen;
        send_and_drain(divider_pkg::op_quotient, 16'd1234, 16'd0);
        send_and_drain(divider_pkg::op_remainder, 16'd1234, 16'd0);
        send_and_drain(divider_pkg::op_quotient, 16'd0, 16'd0);
        send_and_drain(divider_pkg::op_remainder, 16'hffff, 16'd0);
        report_test("divide by zero", mark_errors, mark_results);

        mark_errors  = checker_errors + reset_errors;
        mark_results = results_seen;
        send_random_burst(random_count);
        report_test("random back to back", mark_errors, mark_results);

        mark_errors  = checker_errors + reset_errors;
        mark_results = results_seen;
        throttle <= 1'b1;
        send_random_burst(random_count);
        throttle <= 1'b0;
        report_test("random with back-pressure", mark_errors, mark_results);

        $display("%0d tests passed, %0d tests failed, %0d results checked",
                 tests_passed, tests_failed, results_seen);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* all.f */
common/divider_pkg.sv
logic/pipeline_skid_buffer.sv
lane/iterative_divider.sv
lane/pulse_to_pipeline.sv
lane/divider_lane.sv
logic/lane_dispatcher.sv
logic/lane_collector.sv
logic/divider_array.sv
test/divider_checker.sv
test/tb_divider_array.sv

/* run.sh */
#!/bin/sh
# builds the divider array testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_divider_array -f all.f \
    > build.log 2>&1 || { cat build.log; echo "BUILD FAILED"; exit 1; }
./obj_dir/Vtb_divider_array > sim.log 2>&1
cat sim.log
grep -qx "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
